//--- common/qspinor_pkg.sv
`default_nettype none

package qspinor_pkg;

    localparam int nor_va_width = 24;  // 3-byte addressing only
    localparam int bus_width    = 32;

    // lane width codes
    typedef logic [1:0] lane_width_t;

    localparam lane_width_t x1 = 2'd0;
    localparam lane_width_t x2 = 2'd1;
    localparam lane_width_t x4 = 2'd2;

    typedef enum logic [1:0] {
        acc_1b = 2'd0,
        acc_2b = 2'd1,
        acc_4b = 2'd2
    } bus_acc_t;

    // shift engine unit type
    typedef enum logic [1:0] {
        io_tx  = 2'd0,
        io_rx  = 2'd1,
        io_dmy = 2'd2
    } io_kind_t;

    localparam logic       sclk_idle       = 1'b0;     // spi mode 0
    localparam logic [3:0] dmy_out_pattern = 4'b0000;

    // flash config, same layout as NORCSR
    typedef struct packed {
        logic [7:0] cmd;
        logic [3:0] dmy_cnt;
        logic       dmy_dir;  // 1: master drives lanes during dummies
        logic [2:0] mode;     // 0-111 1-112 2-114 3-122 4-144 5-222 6-444
    } nor_cfg_t;

    typedef struct packed {
        logic [nor_va_width-1:0] addr;
        bus_acc_t                acc;
        logic                    w_rb;
        logic [bus_width-1:0]    wdata;
    } bus_req_t;

    typedef struct packed {
        io_kind_t    kind;
        lane_width_t width;
        logic [7:0]  txd;
        logic        dmy_dir;
    } io_req_t;

    typedef struct packed {
        io_kind_t   kind;
        logic [7:0] rxd;
    } io_resp_t;

endpackage

`default_nettype wire

//--- qspinor_io/qspinor_io.sv
`timescale 1ns/1ps
`default_nettype none

// lane shift engine, one byte or one dummy pulse per request
module qspinor_io (
    input  logic                  clk,
    input  logic                  rstn,

    input  qspinor_pkg::io_req_t  io_req,
    input  logic                  io_req_vld,
    output qspinor_pkg::io_resp_t io_resp,
    output logic                  io_done,

    output logic                  qspi_sclk,
    output logic [3:0]            qspi_dir,
    output logic [3:0]            qspi_mosi,
    input  logic [3:0]            qspi_miso
);

    logic                     busy;
    logic [3:0]               cnt;
    logic [3:0]               cnt_load;
    qspinor_pkg::io_kind_t    kind;
    qspinor_pkg::lane_width_t width;
    logic [7:0]               txd;
    logic                     dmy_dir;
    logic [7:0]               rxd;
    logic [3:0]               lane_en;
    logic [3:0]               tx_bits;

    // two cycles per bit group
    always_comb begin
        if (io_req.kind == qspinor_pkg::io_dmy) begin
            cnt_load = 4'd1;
        end else begin
            case (io_req.width)
                qspinor_pkg::x1: cnt_load = 4'd15;
                qspinor_pkg::x2: cnt_load = 4'd7;
                default:         cnt_load = 4'd3;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
        end else if (io_req_vld) begin
            busy <= 1'b1;
            cnt  <= cnt_load;
        end else if (busy) begin
            if (cnt == 4'd0)
                busy <= 1'b0;
            else
                cnt <= cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (io_req_vld) begin
            kind    <= io_req.kind;
            width   <= io_req.width;
            txd     <= io_req.txd;
            dmy_dir <= io_req.dmy_dir;
        end
    end

    assign io_done = busy && (cnt == 4'd0);

    always_comb begin
        case (width)
            qspinor_pkg::x1: begin
                lane_en = 4'b0001;
                tx_bits = {3'b000, txd[cnt[3:1]]};
            end
            qspinor_pkg::x2: begin
                lane_en = 4'b0011;
                tx_bits = {2'b00, txd[{cnt[2:1], 1'b0} +: 2]};
            end
            default: begin
                lane_en = 4'b1111;
                tx_bits = txd[{cnt[1], 2'b00} +: 4];
            end
        endcase
    end

    always_comb begin
        qspi_sclk = qspinor_pkg::sclk_idle;
        qspi_dir  = 4'b0000;  // all lanes input when idle
        qspi_mosi = 4'b0000;
        if (busy) begin
            qspi_sclk = ~cnt[0];  // low then high
            if (kind == qspinor_pkg::io_tx) begin
                qspi_dir  = lane_en;
                qspi_mosi = tx_bits;
            end else if (kind == qspinor_pkg::io_dmy && dmy_dir) begin
                qspi_dir  = lane_en;
                qspi_mosi = qspinor_pkg::dmy_out_pattern & lane_en;
            end
        end
    end

    // sample on rising sclk, msb first
    always_ff @(posedge clk) begin
        if (busy && kind == qspinor_pkg::io_rx && cnt[0]) begin
            case (width)
                qspinor_pkg::x1: rxd <= {rxd[6:0], qspi_miso[1]};  // x1 reads from io1
                qspinor_pkg::x2: rxd <= {rxd[5:0], qspi_miso[1:0]};
                default:         rxd <= {rxd[3:0], qspi_miso};
            endcase
        end
    end

    assign io_resp.kind = kind;
    assign io_resp.rxd  = rxd;

    a_req_when_free: assert property (@(posedge clk) disable iff (!rstn)
        io_req_vld |-> (!busy || io_done));

endmodule

`default_nettype wire

//--- qspinor_read/qspinor_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// bus read sequencer for the cmd / addr / dummy / data phases
module qspinor_read_ctrl (
    input  logic                              clk,
    input  logic                              rstn,

    input  qspinor_pkg::nor_cfg_t             cfg,
    input  qspinor_pkg::bus_req_t             bus,
    input  logic                              req,
    output logic [qspinor_pkg::bus_width-1:0] rdata,
    output logic                              resp,
    output logic                              fault,

    output logic                              qspi_csb,

    output qspinor_pkg::io_req_t              io_req,
    output logic                              io_req_vld,
    input  qspinor_pkg::io_resp_t             io_resp,
    input  logic                              io_done
);

    typedef enum logic [2:0] {
        st_idle, st_prep, st_cmd, st_addr, st_dmy, st_data
    } state_t;

    state_t                                state, next_state;
    logic [3:0]                            cnt, next_cnt;
    logic                                  invld;
    logic                                  accept;
    logic [qspinor_pkg::nor_va_width-1:0]  lat_addr;
    qspinor_pkg::bus_acc_t                 lat_acc;
    logic [3:0]                            last_idx;
    qspinor_pkg::lane_width_t              cmd_w, addr_w, data_w;

    assign invld = bus.w_rb
                || (bus.addr[0] && bus.acc != qspinor_pkg::acc_1b)
                || (bus.addr[1:0] == 2'd2 && bus.acc == qspinor_pkg::acc_4b);
    assign fault  = req && invld;
    assign accept = req && !invld && state == st_idle;

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_addr <= bus.addr;
            lat_acc  <= bus.acc;
        end
    end

    always_comb begin
        case (lat_acc)
            qspinor_pkg::acc_4b: last_idx = 4'd3;
            qspinor_pkg::acc_2b: last_idx = 4'd1;
            default:             last_idx = 4'd0;
        endcase
    end

    // lane widths per phase
    always_comb begin
        cmd_w  = qspinor_pkg::x1;
        addr_w = qspinor_pkg::x1;
        data_w = qspinor_pkg::x1;
        case (cfg.mode)
            3'd1: data_w = qspinor_pkg::x2;
            3'd2: data_w = qspinor_pkg::x4;
            3'd3: begin
                addr_w = qspinor_pkg::x2;
                data_w = qspinor_pkg::x2;
            end
            3'd4: begin
                addr_w = qspinor_pkg::x4;
                data_w = qspinor_pkg::x4;
            end
            3'd5: begin
                cmd_w  = qspinor_pkg::x2;
                addr_w = qspinor_pkg::x2;
                data_w = qspinor_pkg::x2;
            end
            3'd6: begin
                cmd_w  = qspinor_pkg::x4;
                addr_w = qspinor_pkg::x4;
                data_w = qspinor_pkg::x4;
            end
            default: ;  // 7 falls back to 111
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
            cnt   <= 4'd0;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        case (state)
            st_idle: begin
                if (accept)
                    next_state = st_prep;
            end
            st_prep: begin
                next_state = st_cmd;
                next_cnt   = 4'd0;
            end
            st_cmd: begin
                if (io_done) begin
                    next_state = st_addr;
                    next_cnt   = 4'd2;  // high address byte first
                end
            end
            st_addr: begin
                if (io_done) begin
                    if (cnt != 4'd0) begin
                        next_cnt = cnt - 4'd1;
                    end else if (cfg.dmy_cnt != 4'd0) begin
                        next_state = st_dmy;
                        next_cnt   = cfg.dmy_cnt;
                    end else begin
                        next_state = st_data;
                        next_cnt   = 4'd0;
                    end
                end
            end
            st_dmy: begin
                if (io_done) begin
                    if (cnt == 4'd1) begin
                        next_state = st_data;
                        next_cnt   = 4'd0;
                    end else begin
                        next_cnt = cnt - 4'd1;
                    end
                end
            end
            st_data: begin
                if (io_done) begin
                    if (cnt == last_idx)
                        next_state = st_idle;
                    else
                        next_cnt = cnt + 4'd1;  // byte index
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // next unit goes out in the io_done cycle so units run back to back
    assign io_req_vld = (state == st_prep) || (io_done && next_state != st_idle);

    always_comb begin
        io_req.kind    = qspinor_pkg::io_tx;
        io_req.width   = cmd_w;
        io_req.txd     = cfg.cmd;
        io_req.dmy_dir = cfg.dmy_dir;
        case (next_state)
            st_addr: begin
                io_req.width = addr_w;
                io_req.txd   = lat_addr[{next_cnt[1:0], 3'b000} +: 8];
            end
            st_dmy: begin
                io_req.kind  = qspinor_pkg::io_dmy;
                io_req.width = addr_w;  // dummies run at address width
            end
            st_data: begin
                io_req.kind  = qspinor_pkg::io_rx;
                io_req.width = data_w;
            end
            default: ;
        endcase
    end

    assign qspi_csb = (state == st_idle);

    // little endian with unused lanes left at zero
    always_ff @(posedge clk) begin
        if (accept)
            rdata <= '0;
        else if (state == st_data && io_done && io_resp.kind == qspinor_pkg::io_rx)
            rdata[{cnt[1:0], 3'b000} +: 8] <= io_resp.rxd;
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            resp <= 1'b0;
        else
            resp <= (state != st_idle) && (next_state == st_idle);
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!rstn)
        (state != st_idle) |-> !req);

    a_no_done_idle: assert property (@(posedge clk) disable iff (!rstn)
        (state == st_idle) |-> !io_done);

endmodule

`default_nettype wire

//--- source/qspinor_xip_reader.sv
`timescale 1ns/1ps
`default_nettype none

// memory-mapped read path of the quad spi nor master
module qspinor_xip_reader (
    input  logic                              clk,
    input  logic                              rstn,

    input  qspinor_pkg::nor_cfg_t             cfg,   // hold stable during a read
    input  qspinor_pkg::bus_req_t             bus,
    input  logic                              req,
    output logic [qspinor_pkg::bus_width-1:0] rdata,
    output logic                              resp,
    output logic                              fault,

    output logic                              qspi_csb,
    output logic                              qspi_sclk,
    output logic [3:0]                        qspi_dir,
    output logic [3:0]                        qspi_mosi,
    input  logic [3:0]                        qspi_miso
);

    qspinor_pkg::io_req_t  io_req;
    logic                  io_req_vld;
    qspinor_pkg::io_resp_t io_resp;
    logic                  io_done;

    qspinor_read_ctrl i_qspinor_read_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .cfg        (cfg),
        .bus        (bus),
        .req        (req),
        .rdata      (rdata),
        .resp       (resp),
        .fault      (fault),
        .qspi_csb   (qspi_csb),
        .io_req     (io_req),
        .io_req_vld (io_req_vld),
        .io_resp    (io_resp),
        .io_done    (io_done)
    );

    qspinor_io i_qspinor_io (
        .clk        (clk),
        .rstn       (rstn),
        .io_req     (io_req),
        .io_req_vld (io_req_vld),
        .io_resp    (io_resp),
        .io_done    (io_done),
        .qspi_sclk  (qspi_sclk),
        .qspi_dir   (qspi_dir),
        .qspi_mosi  (qspi_mosi),
        .qspi_miso  (qspi_miso)
    );

endmodule

`default_nettype wire

//--- testbench/qspinor_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral nor flash, read only, pins looked at in the middle of each clk cycle
module qspinor_flash_model (
    input  logic                  clk,
    input  qspinor_pkg::nor_cfg_t cfg,
    input  logic                  qspi_csb,
    input  logic                  qspi_sclk,
    input  logic [3:0]            qspi_dir,
    input  logic [3:0]            qspi_mosi,
    output logic [3:0]            qspi_miso,
    output logic [7:0]            cap_cmd,
    output logic [23:0]           cap_addr,
    output int                    pulses,   // rising sclk edges while selected
    output logic [3:0][3:0]       dir_or,   // cmd, addr, dummy, data
    output logic [3:0][3:0]       dir_and
);

    logic       prev_csb  = 1'b1;
    logic       prev_sclk = 1'b0;
    int         n_cmd, n_addr, n_hdr, w, ph, pos;
    logic [7:0] dbyte;

    // lanes per phase, read off the mode name (114 etc)
    function automatic int lanes(input logic [2:0] mode, input int phase);
        logic [11:0] name;
        case (mode)
            3'd1:    name = 12'h112;
            3'd2:    name = 12'h114;
            3'd3:    name = 12'h122;
            3'd4:    name = 12'h144;
            3'd5:    name = 12'h222;
            3'd6:    name = 12'h444;
            default: name = 12'h111;
        endcase
        return name[(2 - phase) * 4 +: 4];
    endfunction

    function automatic logic [3:0] lane_mask(input int n);
        return (n == 1) ? 4'b0001 : (n == 2) ? 4'b0011 : 4'b1111;
    endfunction

    initial qspi_miso = 4'b0000;

    always @(negedge clk) begin
        n_cmd  = 8 / lanes(cfg.mode, 0);
        n_addr = n_cmd + 24 / lanes(cfg.mode, 1);
        n_hdr  = n_addr + cfg.dmy_cnt;
        if (!qspi_csb && prev_csb) begin
            pulses   = 0;
            cap_cmd  = '0;
            cap_addr = '0;
            dir_or   = '0;
            dir_and  = '1;
        end else if (!qspi_csb && qspi_sclk && !prev_sclk) begin
            ph = (pulses < n_cmd) ? 0 : (pulses < n_addr) ? 1 : (pulses < n_hdr) ? 2 : 3;
            w  = lanes(cfg.mode, (ph == 0) ? 0 : 1);
            if (ph == 0)
                cap_cmd = (cap_cmd << w) | (qspi_mosi & lane_mask(w));
            else if (ph == 1)
                cap_addr = (cap_addr << w) | (qspi_mosi & lane_mask(w));
            dir_or[ph]  = dir_or[ph] | qspi_dir;
            dir_and[ph] = dir_and[ph] & qspi_dir;
            pulses++;
        end else if (!qspi_csb && !qspi_sclk && prev_sclk && pulses >= n_hdr) begin
            // next data bit group goes out on falling sclk
            w     = lanes(cfg.mode, 2);
            pos   = (pulses - n_hdr) * w;  // data bits already sent
            dbyte = (cap_addr[7:0] + pos / 8) ^ 8'hA5;
            dbyte = (dbyte >> (8 - w - pos % 8)) & lane_mask(w);
            qspi_miso = (w == 1) ? {dbyte[2:0], 1'b0} : dbyte[3:0];  // x1 answers on io1
        end
        prev_csb  = qspi_csb;
        prev_sclk = qspi_sclk;
    end

endmodule

`default_nettype wire

//--- testbench/tb_qspinor_xip_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qspinor_xip_reader;

    typedef struct packed {
        logic [2:0]            mode;
        qspinor_pkg::bus_acc_t acc;
        logic [3:0]            dmy_cnt;
        logic                  dmy_dir;
        logic [1:0]            ofs;  // address bits below the alignment
        logic                  wr;
        logic                  flt;  // fault expected
    } row_t;

    localparam int          n_rows    = 14;
    localparam int          resp_wait = 1000;
    localparam int          idle_wait = 100;
    localparam logic [31:0] seed      = 32'd94;

    logic                  clk = 1'b0;
    logic                  rstn;
    qspinor_pkg::nor_cfg_t cfg;
    qspinor_pkg::bus_req_t bus;
    logic                  req, resp, fault;
    logic [31:0]           rdata;
    logic                  qspi_csb, qspi_sclk;
    logic [3:0]            qspi_dir, qspi_mosi, qspi_miso;
    logic [7:0]            cap_cmd;
    logic [23:0]           cap_addr;
    int                    pulses;
    logic [3:0][3:0]       dir_or, dir_and;
    row_t                  rows [n_rows];
    logic [31:0]           rng;

    always #20 clk = ~clk;

    qspinor_xip_reader i_qspinor_xip_reader (
        .clk       (clk),
        .rstn      (rstn),
        .cfg       (cfg),
        .bus       (bus),
        .req       (req),
        .rdata     (rdata),
        .resp      (resp),
        .fault     (fault),
        .qspi_csb  (qspi_csb),
        .qspi_sclk (qspi_sclk),
        .qspi_dir  (qspi_dir),
        .qspi_mosi (qspi_mosi),
        .qspi_miso (qspi_miso)
    );

    qspinor_flash_model i_flash (
        .clk       (clk),
        .cfg       (cfg),
        .qspi_csb  (qspi_csb),
        .qspi_sclk (qspi_sclk),
        .qspi_dir  (qspi_dir),
        .qspi_mosi (qspi_mosi),
        .qspi_miso (qspi_miso),
        .cap_cmd   (cap_cmd),
        .cap_addr  (cap_addr),
        .pulses    (pulses),
        .dir_or    (dir_or),
        .dir_and   (dir_and)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic row_t make_row(input logic [2:0] mode, input qspinor_pkg::bus_acc_t acc,
                                      input logic [3:0] dmy_cnt, input logic dmy_dir,
                                      input logic [1:0] ofs, input logic wr, input logic flt);
        return {mode, acc, dmy_cnt, dmy_dir, ofs, wr, flt};
    endfunction

    // cmd, addr, data digit of the mode name
    function automatic int lanes(input logic [2:0] mode, input int phase);
        logic [11:0] name;
        case (mode)
            3'd1:    name = 12'h112;
            3'd2:    name = 12'h114;
            3'd3:    name = 12'h122;
            3'd4:    name = 12'h144;
            3'd5:    name = 12'h222;
            3'd6:    name = 12'h444;
            default: name = 12'h111;
        endcase
        return name[(2 - phase) * 4 +: 4];
    endfunction

    function automatic logic [3:0] lane_mask(input int n);
        return (n == 1) ? 4'b0001 : (n == 2) ? 4'b0011 : 4'b1111;
    endfunction

    // flash byte at address a is a[7:0] ^ A5, little endian on the bus
    function automatic logic [31:0] expected_rdata(input logic [23:0] addr, input int n_bytes);
        logic [31:0] d;
        logic [7:0]  a;
        d = '0;
        for (int i = 0; i < n_bytes; i++) begin
            a = addr[7:0] + i;
            d[i * 8 +: 8] = a ^ 8'hA5;
        end
        return d;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic run_row(input row_t r);
        qspinor_pkg::nor_cfg_t c;
        qspinor_pkg::bus_req_t b;
        int                    n_bytes, cw, aw, dw, waited;
        rng       = xorshift32(rng);
        c.cmd     = rng[31:24];
        c.dmy_cnt = r.dmy_cnt;
        c.dmy_dir = r.dmy_dir;
        c.mode    = r.mode;
        b.addr    = {rng[23:2], r.ofs};
        b.acc     = r.acc;
        b.w_rb    = r.wr;
        b.wdata   = ~rng;
        n_bytes   = (r.acc == qspinor_pkg::acc_4b) ? 4 : (r.acc == qspinor_pkg::acc_2b) ? 2 : 1;
        cw        = lanes(r.mode, 0);
        aw        = lanes(r.mode, 1);
        dw        = lanes(r.mode, 2);
        @(posedge clk);
        cfg <= c;
        @(posedge clk);
        bus <= b;
        req <= 1'b1;
        @(negedge clk);
        check_eq(fault, r.flt, "fault in the req cycle");
        @(posedge clk);
        req <= 1'b0;
        if (r.flt) begin
            for (waited = 0; waited < idle_wait; waited++) begin
                @(negedge clk);
                check_eq(resp, 1'b0, "resp after a faulted req");
                check_eq(qspi_csb, 1'b1, "qspi_csb after a faulted req");
            end
        end else begin
            waited = 0;
            @(negedge clk);
            while (resp !== 1'b1 && waited < resp_wait) begin
                @(negedge clk);
                waited++;
            end
            if (resp !== 1'b1) begin
                $display("timeout: no resp within %0d cycles after a read request", resp_wait);
                $display("SIMULATION FAILED");
                $fatal(1, "read did not complete");
            end else begin
                check_eq(rdata, expected_rdata(b.addr, n_bytes), "rdata");
                check_eq(qspi_csb, 1'b1, "qspi_csb in the resp cycle");
                check_eq(cap_cmd, c.cmd, "command seen by the flash");
                check_eq(cap_addr, b.addr, "address seen by the flash");
                check_eq(pulses, 8 / cw + 24 / aw + r.dmy_cnt + n_bytes * 8 / dw, "sclk pulses");
                check_eq({dir_or[0], dir_and[0]}, {2{lane_mask(cw)}}, "qspi_dir during command");
                check_eq({dir_or[1], dir_and[1]}, {2{lane_mask(aw)}}, "qspi_dir during address");
                check_eq({dir_or[3], dir_and[3]}, 8'h00, "qspi_dir during data");
                if (r.mode == 3'd4 && r.dmy_cnt != 4'd0)
                    check_eq({dir_or[2], dir_and[2]}, r.dmy_dir ? 8'hFF : 8'h00,
                             "qspi_dir during dummies");
            end
        end
    endtask

    initial begin
        rstn = 1'b0;
        cfg  = '0;
        bus  = '0;
        req  = 1'b0;
        rng  = seed;
        //                 mode  size                dmy    ddir  ofs   wr    fault
        rows[0]  = make_row(3'd0, qspinor_pkg::acc_4b, 4'd0, 1'b0, 2'd0, 1'b0, 1'b0);
        rows[1]  = make_row(3'd1, qspinor_pkg::acc_2b, 4'd8, 1'b0, 2'd2, 1'b0, 1'b0);
        rows[2]  = make_row(3'd0, qspinor_pkg::acc_1b, 4'd0, 1'b0, 2'd0, 1'b1, 1'b1);
        rows[3]  = make_row(3'd2, qspinor_pkg::acc_1b, 4'd8, 1'b0, 2'd3, 1'b0, 1'b0);
        rows[4]  = make_row(3'd3, qspinor_pkg::acc_4b, 4'd1, 1'b0, 2'd0, 1'b0, 1'b0);
        rows[5]  = make_row(3'd4, qspinor_pkg::acc_4b, 4'd6, 1'b1, 2'd0, 1'b0, 1'b0);
        rows[6]  = make_row(3'd4, qspinor_pkg::acc_2b, 4'd1, 1'b0, 2'd1, 1'b0, 1'b1);
        rows[7]  = make_row(3'd4, qspinor_pkg::acc_2b, 4'd4, 1'b0, 2'd2, 1'b0, 1'b0);
        rows[8]  = make_row(3'd5, qspinor_pkg::acc_1b, 4'd1, 1'b1, 2'd1, 1'b0, 1'b0);
        rows[9]  = make_row(3'd6, qspinor_pkg::acc_4b, 4'd3, 1'b0, 2'd3, 1'b0, 1'b1);
        rows[10] = make_row(3'd6, qspinor_pkg::acc_4b, 4'd8, 1'b1, 2'd0, 1'b0, 1'b0);
        rows[11] = make_row(3'd6, qspinor_pkg::acc_2b, 4'd0, 1'b0, 2'd0, 1'b0, 1'b0);
        rows[12] = make_row(3'd5, qspinor_pkg::acc_4b, 4'd2, 1'b0, 2'd2, 1'b0, 1'b1);
        rows[13] = make_row(3'd0, qspinor_pkg::acc_1b, 4'd8, 1'b0, 2'd1, 1'b0, 1'b0);
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_eq(qspi_csb, 1'b1, "qspi_csb after reset");
        check_eq(resp, 1'b0, "resp after reset");
        check_eq(qspi_sclk, 1'b0, "qspi_sclk after reset");
        check_eq(qspi_dir, 4'b0000, "qspi_dir after reset");
        for (int i = 0; i < n_rows; i++)
            run_row(rows[i]);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/qspinor_pkg.sv
qspinor_io/qspinor_io.sv
qspinor_read/qspinor_read_ctrl.sv
source/qspinor_xip_reader.sv
testbench/qspinor_flash_model.sv
testbench/tb_qspinor_xip_reader.sv

//--- Bender.yml
package:
  name: qspinor_xip_reader

sources:
  - common/qspinor_pkg.sv
  - qspinor_io/qspinor_io.sv
  - qspinor_read/qspinor_read_ctrl.sv
  - source/qspinor_xip_reader.sv
  - target: simulation
    files:
      - testbench/qspinor_flash_model.sv
      - testbench/tb_qspinor_xip_reader.sv
